// File: artemis_pcie_core.f
source/pcie_tlp_pkg.sv
source/pcie_ctrl_pkg.sv
source/pcie_ingress.sv
source/pcie_control.sv
source/pcie_egress.sv
source/pcie_interrupt.sv
source/artemis_pcie_core.sv
verification/tb_artemis_pcie_core.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_artemis_pcie_core
FILELIST  ?= artemis_pcie_core.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: verification/tb_artemis_pcie_core.sv
// Directed top-level tests; the hard PCIe core is modelled only by its ready signals, MSI width 8
module tb_artemis_pcie_core;
  import pcie_tlp_pkg::*;

  localparam int          TIMEOUT_CYCLES = 4000;
  localparam logic [31:0] BAR_BASE       = 32'hF000_0000;
  localparam logic [15:0] TB_RID         = 16'h0100;
  localparam logic [31:0] STATUS_ADDR    = 32'h0008_1007;
  localparam logic [31:0] PING_VALUE     = 32'hC0FF_EE01;
  // Fmt 2 type 0 is a 32-bit memory write, fmt 0 type 0 a 32-bit memory read
  localparam logic [7:0]  FT_MWR32       = {3'd2, 5'd0};
  localparam logic [7:0]  FT_MRD32       = {3'd0, 5'd0};
  localparam logic [1:0]  IDX_STATUS     = 2'd0;
  localparam logic [1:0]  IDX_PING       = 2'd1;
  localparam logic [1:0]  IDX_COMMAND    = 2'd2;
  localparam logic [1:0]  IDX_MSI        = 2'd3;
  localparam logic [7:0]  OP_RESET       = 8'h01;
  localparam logic [7:0]  OP_PING        = 8'h02;
  localparam logic [7:0]  OP_IRQ         = 8'h03;

  logic                 clk_62p5;
  logic                 pcie_reset;
  axis_beat_t           i_rx_beat;
  logic                 i_rx_valid;
  logic [BAR_COUNT-1:0] i_rx_bar_hit;
  requester_id_t        i_requester_id;
  logic                 i_tx_ready;
  logic                 i_cfg_interrupt_rdy;
  logic                 o_rx_ready;
  axis_beat_t           o_tx_beat;
  logic                 o_tx_valid;
  logic                 o_cfg_interrupt;
  logic [7:0]           o_cfg_interrupt_di;
  logic                 o_sys_rst;

  axis_beat_t tx_q[$];
  int         cycle_count;
  int         sys_rst_count;
  bit         stall_en;
  logic [7:0] next_tag;

  artemis_pcie_core #(
    .CONTROL_BAR      (0),
    .MSI_VECTOR_WIDTH (8)
  ) dut (.*);

  always #20 clk_62p5 = ~clk_62p5;

  // Transmit ready with random stalls only while enabled
  always @(posedge clk_62p5) begin
    #2;
    if (stall_en) begin
      i_tx_ready = ($urandom_range(0, 2) != 0);
    end else begin
      i_tx_ready = 1'b1;
    end
  end

  // Accepted transmit beats and reset pulses
  always @(posedge clk_62p5) begin
    if (!pcie_reset) begin
      if (o_tx_valid && i_tx_ready) begin
        tx_q.push_back(o_tx_beat);
      end
      if (o_sys_rst) begin
        sys_rst_count = sys_rst_count + 1;
      end
    end
  end

  always @(posedge clk_62p5) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Simulation timed out after %0d cycles without finishing the tests", cycle_count);
      $display("Result: FAILED");
      $fatal(1, "Timeout");
    end
  end

  task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERROR at %0t: %s is %h, expected %h", $time, what, got, exp);
      $display("Result: FAILED");
      $fatal(1, "Check failed");
    end
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk_62p5);
    #2;
  endtask

  task automatic drive_beat(input logic [31:0] dword, input logic last);
    i_rx_beat  = '{data: dword, keep: 4'hF, last: last};
    i_rx_valid = 1'b1;
    @(posedge clk_62p5);
    while (!o_rx_ready) begin
      @(posedge clk_62p5);
    end
    #2;
    i_rx_valid = 1'b0;
  endtask

  // Header and optional payload with the BAR hit only on the first beat
  task automatic send_tlp(input logic [7:0] fmt_type, input logic [31:0] addr,
                          input logic [31:0] payload, input logic [BAR_COUNT-1:0] bar_hit);
    logic has_payload;
    has_payload  = (fmt_type == FT_MWR32);
    i_rx_bar_hit = bar_hit;
    drive_beat({fmt_type, 14'd0, 10'd1}, 1'b0);
    i_rx_bar_hit = '0;
    drive_beat({16'h0000, 8'h00, 4'h0, 4'hF}, 1'b0);
    drive_beat(addr, !has_payload);
    if (has_payload) begin
      drive_beat(payload, 1'b1);
    end
  endtask

  task automatic write_reg(input logic [1:0] idx, input logic [31:0] value);
    send_tlp(FT_MWR32, {BAR_BASE[31:4], idx, 2'b00}, value, 7'b0000001);
  endtask

  task automatic check_tlp(input logic [31:0] addr, input logic [31:0] payload);
    axis_beat_t  beat;
    logic [31:0] exp_dw [4];
    exp_dw[0] = {FT_MWR32, 14'd0, 10'd1};
    exp_dw[1] = {TB_RID, next_tag, 4'h0, 4'hF};
    exp_dw[2] = {addr[31:2], 2'b00};
    exp_dw[3] = payload;
    while (tx_q.size() < 4) begin
      @(posedge clk_62p5);
      #2;
    end
    for (int i = 0; i < 4; i++) begin
      beat = tx_q.pop_front();
      check_value($sformatf("tx beat %0d data", i), beat.data, exp_dw[i]);
      check_value($sformatf("tx beat %0d keep", i), 32'(beat.keep), 32'hF);
      check_value($sformatf("tx beat %0d last", i), 32'(beat.last), (i == 3) ? 32'd1 : 32'd0);
    end
    next_tag = next_tag + 8'd1;
  endtask

  // Nothing further may leave the transmit port
  task automatic expect_quiet_tx();
    wait_cycles(3);
    check_value("extra tx beats", 32'(tx_q.size()), 32'd0);
  endtask

  task automatic test_ping();
    write_reg(IDX_STATUS, STATUS_ADDR);
    write_reg(IDX_PING, PING_VALUE);
    write_reg(IDX_COMMAND, {24'd0, OP_PING});
    check_tlp(STATUS_ADDR, PING_VALUE);
    expect_quiet_tx();
    // Same ping again so the tag moves on
    write_reg(IDX_COMMAND, {24'd0, OP_PING});
    check_tlp(STATUS_ADDR, PING_VALUE);
    expect_quiet_tx();
  endtask

  task automatic test_backpressure();
    stall_en = 1'b1;
    write_reg(IDX_COMMAND, {24'd0, OP_PING});
    check_tlp(STATUS_ADDR, PING_VALUE);
    stall_en = 1'b0;
    expect_quiet_tx();
  endtask

  task automatic test_interrupt();
    int unsigned delay;
    delay = $urandom_range(0, 10);
    write_reg(IDX_MSI, 32'h0000_00A5);
    write_reg(IDX_COMMAND, {24'd0, OP_IRQ});
    while (!o_cfg_interrupt) begin
      @(posedge clk_62p5);
    end
    #2;
    check_value("msi vector", 32'(o_cfg_interrupt_di), 32'h0000_00A5);
    repeat (delay) begin
      wait_cycles(1);
      check_value("irq held before ready", 32'(o_cfg_interrupt), 32'd1);
    end
    i_cfg_interrupt_rdy = 1'b1;
    wait_cycles(1);
    i_cfg_interrupt_rdy = 1'b0;
    check_value("irq after accept", 32'(o_cfg_interrupt), 32'd0);
    wait_cycles(2);
    check_value("irq stays low", 32'(o_cfg_interrupt), 32'd0);
  endtask

  task automatic test_reset_cmd();
    sys_rst_count = 0;
    write_reg(IDX_COMMAND, {24'd0, OP_RESET});
    wait_cycles(10);
    check_value("sys reset pulse cycles", 32'(sys_rst_count), 32'd1);
    check_value("tx beats after reset cmd", 32'(tx_q.size()), 32'd0);
  endtask

  task automatic test_filtering();
    // Write to BAR 1 and a read to the ping register must both be ignored
    send_tlp(FT_MWR32, {BAR_BASE[31:4], IDX_PING, 2'b00}, 32'hDEAD_BEEF, 7'b0000010);
    send_tlp(FT_MRD32, {BAR_BASE[31:4], IDX_PING, 2'b00}, 32'h0, 7'b0000001);
    write_reg(IDX_COMMAND, {24'd0, OP_PING});
    check_tlp(STATUS_ADDR, PING_VALUE);
    expect_quiet_tx();
    write_reg(IDX_COMMAND, 32'h0000_007F);
    check_tlp(STATUS_ADDR, {16'hBAD0, 8'h00, 8'h7F});
    expect_quiet_tx();
  endtask

  initial begin
    void'($urandom(50797));
    clk_62p5            = 1'b0;
    pcie_reset          = 1'b1;
    i_rx_beat           = '0;
    i_rx_valid          = 1'b0;
    i_rx_bar_hit        = '0;
    i_requester_id      = TB_RID;
    i_tx_ready          = 1'b1;
    i_cfg_interrupt_rdy = 1'b0;
    cycle_count         = 0;
    sys_rst_count       = 0;
    stall_en            = 1'b0;
    next_tag            = 8'd0;
    repeat (8) @(posedge clk_62p5);
    #2;
    pcie_reset = 1'b0;
    wait_cycles(2);
    check_value("rx ready after reset", 32'(o_rx_ready), 32'd1);
    check_value("tx valid after reset", 32'(o_tx_valid), 32'd0);
    check_value("irq after reset", 32'(o_cfg_interrupt), 32'd0);
    check_value("sys reset after reset", 32'(o_sys_rst), 32'd0);
    test_ping();
    test_backpressure();
    test_interrupt();
    test_reset_cmd();
    test_filtering();
    check_value("leftover tx beats", 32'(tx_q.size()), 32'd0);
    $display("Result: PASSED");
    $finish;
  end

endmodule

// File: source/artemis_pcie_core.sv
// User-side logic behind a hard PCIe core in the 62.5 MHz domain; the core itself is not included
module artemis_pcie_core #(
  parameter int CONTROL_BAR      = 0,
  parameter int MSI_VECTOR_WIDTH = 8
) (
  input  logic                               clk_62p5,
  input  logic                               pcie_reset,
  input  pcie_tlp_pkg::axis_beat_t           i_rx_beat,
  input  logic                               i_rx_valid,
  input  logic [pcie_tlp_pkg::BAR_COUNT-1:0] i_rx_bar_hit,
  input  pcie_tlp_pkg::requester_id_t        i_requester_id,
  input  logic                               i_tx_ready,
  input  logic                               i_cfg_interrupt_rdy,
  output logic                               o_rx_ready,
  output pcie_tlp_pkg::axis_beat_t           o_tx_beat,
  output logic                               o_tx_valid,
  output logic                               o_cfg_interrupt,
  output logic [MSI_VECTOR_WIDTH-1:0]        o_cfg_interrupt_di,
  output logic                               o_sys_rst
);
  import pcie_tlp_pkg::*;
  import pcie_ctrl_pkg::*;

  logic                        cmd_stb;
  command_e                    cmd;
  logic [DW_WIDTH-1:0]         status_addr;
  logic [DW_WIDTH-1:0]         ping_value;
  logic [MSI_VECTOR_WIDTH-1:0] reg_msi_vector;
  logic                        egress_stb;
  egress_req_t                 egress_req;
  logic                        egress_finished;
  logic                        msi_stb;
  logic [MSI_VECTOR_WIDTH-1:0] msi_vector;

  pcie_ingress #(
    .CONTROL_BAR      (CONTROL_BAR),
    .MSI_VECTOR_WIDTH (MSI_VECTOR_WIDTH)
  ) ingress (
    .clk_62p5      (clk_62p5),
    .pcie_reset    (pcie_reset),
    .i_rx_beat     (i_rx_beat),
    .i_rx_valid    (i_rx_valid),
    .i_rx_bar_hit  (i_rx_bar_hit),
    .o_rx_ready    (o_rx_ready),
    .o_cmd_stb     (cmd_stb),
    .o_cmd         (cmd),
    .o_status_addr (status_addr),
    .o_ping_value  (ping_value),
    .o_msi_vector  (reg_msi_vector)
  );

  pcie_control #(
    .MSI_VECTOR_WIDTH (MSI_VECTOR_WIDTH)
  ) controller (
    .clk_62p5          (clk_62p5),
    .pcie_reset        (pcie_reset),
    .i_cmd_stb         (cmd_stb),
    .i_cmd             (cmd),
    .i_status_addr     (status_addr),
    .i_ping_value      (ping_value),
    .i_msi_vector      (reg_msi_vector),
    .i_egress_finished (egress_finished),
    .o_egress_stb      (egress_stb),
    .o_egress_req      (egress_req),
    .o_msi_stb         (msi_stb),
    .o_msi_vector      (msi_vector),
    .o_sys_rst         (o_sys_rst)
  );

  pcie_egress egress (
    .clk_62p5       (clk_62p5),
    .pcie_reset     (pcie_reset),
    .i_egress_stb   (egress_stb),
    .i_egress_req   (egress_req),
    .i_requester_id (i_requester_id),
    .i_tx_ready     (i_tx_ready),
    .o_tx_beat      (o_tx_beat),
    .o_tx_valid     (o_tx_valid),
    .o_finished     (egress_finished)
  );

  pcie_interrupt #(
    .MSI_VECTOR_WIDTH (MSI_VECTOR_WIDTH)
  ) msi_irq (
    .clk_62p5            (clk_62p5),
    .pcie_reset          (pcie_reset),
    .i_msi_stb           (msi_stb),
    .i_msi_vector        (msi_vector),
    .i_cfg_interrupt_rdy (i_cfg_interrupt_rdy),
    .o_cfg_interrupt     (o_cfg_interrupt),
    .o_cfg_interrupt_di  (o_cfg_interrupt_di)
  );

endmodule

// File: source/pcie_interrupt.sv
// One MSI request outstanding at a time; a strobe while a request is pending is dropped
module pcie_interrupt #(
  parameter int MSI_VECTOR_WIDTH = 8
) (
  input  logic                         clk_62p5,
  input  logic                         pcie_reset,
  input  logic                         i_msi_stb,
  input  logic [MSI_VECTOR_WIDTH-1:0]  i_msi_vector,
  input  logic                         i_cfg_interrupt_rdy,
  output logic                         o_cfg_interrupt,
  output logic [MSI_VECTOR_WIDTH-1:0]  o_cfg_interrupt_di
);

  typedef enum logic {
    IDLE,
    SEND_INTERRUPT
  } interrupt_state_e;

  interrupt_state_e state;

  always_ff @(posedge clk_62p5) begin
    if (pcie_reset) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE: begin
          if (i_msi_stb) begin
            state <= SEND_INTERRUPT;
          end
        end
        SEND_INTERRUPT: begin
          if (i_cfg_interrupt_rdy) begin
            state <= IDLE;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk_62p5) begin
    if ((state == IDLE) && i_msi_stb) begin
      o_cfg_interrupt_di <= i_msi_vector;
    end
  end

  assign o_cfg_interrupt = (state == SEND_INTERRUPT);

  // Core must see the request until it acknowledges
  assert property (@(posedge clk_62p5) disable iff (pcie_reset)
    o_cfg_interrupt && !i_cfg_interrupt_rdy |=> o_cfg_interrupt);

endmodule

// File: source/pcie_egress.sv
// Sends one single-dword memory write per request; a request during an active TLP is ignored
module pcie_egress (
  input  logic                         clk_62p5,
  input  logic                         pcie_reset,
  input  logic                         i_egress_stb,
  input  pcie_ctrl_pkg::egress_req_t   i_egress_req,
  input  pcie_tlp_pkg::requester_id_t  i_requester_id,
  input  logic                         i_tx_ready,
  output pcie_tlp_pkg::axis_beat_t     o_tx_beat,
  output logic                         o_tx_valid,
  output logic                         o_finished
);
  import pcie_tlp_pkg::*;
  import pcie_ctrl_pkg::*;

  logic [1:0]    beat_idx;
  tlp_tag_t      tag;
  egress_req_t   req_q;
  requester_id_t rid_q;
  tlp_dw0_t      dw0;
  tlp_dw1_t      dw1;
  logic          tx_fire;
  logic          start;

  assign tx_fire = o_tx_valid && i_tx_ready;
  assign start   = i_egress_stb && !o_tx_valid;

  always_comb begin
    dw0 = '{fmt_type: MEM_WRITE32, flags: '0, length: LENGTH_WIDTH'(1)};
    dw1 = '{requester_id: rid_q, tag: tag, last_be: '0, first_be: '1};
    o_tx_beat.keep = '1;
    o_tx_beat.last = (beat_idx == 2'd3);
    case (beat_idx)
      2'd0:    o_tx_beat.data = dw0;
      2'd1:    o_tx_beat.data = dw1;
      // Dword aligned address
      2'd2:    o_tx_beat.data = {req_q.addr[DW_WIDTH-1:2], 2'b00};
      default: o_tx_beat.data = req_q.payload;
    endcase
  end

  always_ff @(posedge clk_62p5) begin
    if (pcie_reset) begin
      o_tx_valid <= 1'b0;
      o_finished <= 1'b0;
      beat_idx   <= '0;
      tag        <= '0;
    end else begin
      o_finished <= 1'b0;
      if (start) begin
        o_tx_valid <= 1'b1;
        beat_idx   <= '0;
      end else if (tx_fire) begin
        if (beat_idx == 2'd3) begin
          o_tx_valid <= 1'b0;
          o_finished <= 1'b1;
          tag        <= tag + tlp_tag_t'(1);
        end else begin
          beat_idx <= beat_idx + 2'd1;
        end
      end
    end
  end

  // Requester id is captured so a config change cannot corrupt a TLP in flight
  always_ff @(posedge clk_62p5) begin
    if (start) begin
      req_q <= i_egress_req;
      rid_q <= i_requester_id;
    end
  end

  assert property (@(posedge clk_62p5) disable iff (pcie_reset)
    o_tx_valid && !i_tx_ready |=> o_tx_valid && $stable(o_tx_beat));

endmodule

// File: source/pcie_control.sv
// Executes one command at a time; commands that arrive while a status write is pending are lost
module pcie_control #(
  parameter int MSI_VECTOR_WIDTH = 8
) (
  input  logic                               clk_62p5,
  input  logic                               pcie_reset,
  input  logic                               i_cmd_stb,
  input  pcie_ctrl_pkg::command_e            i_cmd,
  input  logic [pcie_tlp_pkg::DW_WIDTH-1:0]  i_status_addr,
  input  logic [pcie_tlp_pkg::DW_WIDTH-1:0]  i_ping_value,
  input  logic [MSI_VECTOR_WIDTH-1:0]        i_msi_vector,
  input  logic                               i_egress_finished,
  output logic                               o_egress_stb,
  output pcie_ctrl_pkg::egress_req_t         o_egress_req,
  output logic                               o_msi_stb,
  output logic [MSI_VECTOR_WIDTH-1:0]        o_msi_vector,
  output logic                               o_sys_rst
);
  import pcie_tlp_pkg::*;
  import pcie_ctrl_pkg::*;

  typedef enum logic {
    IDLE,
    WAIT_EGRESS
  } control_state_e;

  control_state_e      state;
  logic                cmd_take;
  logic [DW_WIDTH-1:0] unknown_status;

  assign cmd_take       = (state == IDLE) && i_cmd_stb;
  // Marker on top and the offending opcode in the low byte
  assign unknown_status = {STATUS_UNKNOWN_MARK, 8'h00, i_cmd};

  always_ff @(posedge clk_62p5) begin
    if (pcie_reset) begin
      state        <= IDLE;
      o_egress_stb <= 1'b0;
      o_msi_stb    <= 1'b0;
      o_sys_rst    <= 1'b0;
    end else begin
      o_egress_stb <= 1'b0;
      o_msi_stb    <= 1'b0;
      o_sys_rst    <= 1'b0;
      case (state)
        IDLE: begin
          if (i_cmd_stb) begin
            case (i_cmd)
              CMD_RESET:     o_sys_rst <= 1'b1;
              CMD_INTERRUPT: o_msi_stb <= 1'b1;
              default: begin
                // Ping and unknown opcodes both answer with a status write
                o_egress_stb <= 1'b1;
                state        <= WAIT_EGRESS;
              end
            endcase
          end
        end
        WAIT_EGRESS: begin
          if (i_egress_finished) begin
            state <= IDLE;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk_62p5) begin
    if (cmd_take) begin
      o_egress_req.addr    <= i_status_addr;
      o_egress_req.payload <= (i_cmd == CMD_PING) ? i_ping_value : unknown_status;
      o_msi_vector         <= i_msi_vector;
    end
  end

  // Egress only reports the end of a TLP that control is still waiting on
  assert property (@(posedge clk_62p5) disable iff (pcie_reset)
    i_egress_finished |-> state == WAIT_EGRESS);

endmodule

// File: source/pcie_ingress.sv
// Only single-dword memory writes to CONTROL_BAR are decoded; all other TLPs are drained unread
module pcie_ingress #(
  parameter int CONTROL_BAR      = 0,
  parameter int MSI_VECTOR_WIDTH = 8
) (
  input  logic                                clk_62p5,
  input  logic                                pcie_reset,
  input  pcie_tlp_pkg::axis_beat_t            i_rx_beat,
  input  logic                                i_rx_valid,
  input  logic [pcie_tlp_pkg::BAR_COUNT-1:0]  i_rx_bar_hit,
  output logic                                o_rx_ready,
  output logic                                o_cmd_stb,
  output pcie_ctrl_pkg::command_e             o_cmd,
  output logic [pcie_tlp_pkg::DW_WIDTH-1:0]   o_status_addr,
  output logic [pcie_tlp_pkg::DW_WIDTH-1:0]   o_ping_value,
  output logic [MSI_VECTOR_WIDTH-1:0]         o_msi_vector
);
  import pcie_tlp_pkg::*;
  import pcie_ctrl_pkg::*;

  typedef enum logic [1:0] {
    ST_HEADER,
    ST_PAYLOAD,
    ST_DRAIN
  } ingress_state_e;

  ingress_state_e state;
  logic [1:0]     beat_cnt;
  logic           hdr_match;
  reg_index_e     reg_idx;
  tlp_dw0_t       hdr_dw0;
  logic           rx_fire;

  assign rx_fire = i_rx_valid && o_rx_ready;
  assign hdr_dw0 = tlp_dw0_t'(i_rx_beat.data);

  always_ff @(posedge clk_62p5) begin
    if (pcie_reset) begin
      o_rx_ready    <= 1'b0;
      state         <= ST_HEADER;
      beat_cnt      <= '0;
      hdr_match     <= 1'b0;
      reg_idx       <= REG_STATUS_ADDR;
      o_cmd_stb     <= 1'b0;
      o_cmd         <= command_e'(8'h00);
      o_status_addr <= '0;
      o_ping_value  <= '0;
      o_msi_vector  <= '0;
    end else begin
      o_rx_ready <= 1'b1;
      o_cmd_stb  <= 1'b0;
      if (rx_fire) begin
        case (state)
          ST_HEADER: begin
            // BAR hit is only valid alongside the first beat
            if (beat_cnt == 2'd0) begin
              hdr_match <= (hdr_dw0.fmt_type == MEM_WRITE32) &&
                           (hdr_dw0.length == LENGTH_WIDTH'(1)) &&
                           i_rx_bar_hit[CONTROL_BAR];
            end
            if (beat_cnt == 2'd2) begin
              reg_idx <= reg_index_e'(i_rx_beat.data[REG_ADDR_LSB +: REG_INDEX_WIDTH]);
            end
            if (i_rx_beat.last) begin
              // Header-only TLP such as a memory read
              beat_cnt <= '0;
            end else if (beat_cnt == 2'd2) begin
              beat_cnt <= '0;
              state    <= hdr_match ? ST_PAYLOAD : ST_DRAIN;
            end else begin
              beat_cnt <= beat_cnt + 2'd1;
            end
          end
          ST_PAYLOAD: begin
            case (reg_idx)
              REG_STATUS_ADDR: o_status_addr <= i_rx_beat.data;
              REG_PING_VALUE:  o_ping_value  <= i_rx_beat.data;
              REG_COMMAND: begin
                o_cmd_stb <= 1'b1;
                o_cmd     <= command_e'(i_rx_beat.data[$bits(command_e)-1:0]);
              end
              REG_MSI_VECTOR:  o_msi_vector  <= i_rx_beat.data[MSI_VECTOR_WIDTH-1:0];
            endcase
            state <= i_rx_beat.last ? ST_HEADER : ST_DRAIN;
          end
          default: begin
            if (i_rx_beat.last) begin
              state <= ST_HEADER;
            end
          end
        endcase
      end
    end
  end

  // Length 1 in the header means the payload beat must close the TLP
  assert property (@(posedge clk_62p5) disable iff (pcie_reset)
    rx_fire && (state == ST_PAYLOAD) |-> i_rx_beat.last);

endmodule

// File: source/pcie_ctrl_pkg.sv
// Control BAR register map and command set; registers sit at dword offsets 0 to 3 of the BAR
package pcie_ctrl_pkg;

  localparam int REG_INDEX_WIDTH = 2;
  // Register index lives in address bits 3:2
  localparam int REG_ADDR_LSB    = 2;

  typedef enum logic [REG_INDEX_WIDTH-1:0] {
    REG_STATUS_ADDR = 2'd0,
    REG_PING_VALUE  = 2'd1,
    REG_COMMAND     = 2'd2,
    REG_MSI_VECTOR  = 2'd3
  } reg_index_e;

  // Opcode comes from payload bits 7:0
  // Values outside this list are reported as unknown
  typedef enum logic [7:0] {
    CMD_RESET     = 8'h01,
    CMD_PING      = 8'h02,
    CMD_INTERRUPT = 8'h03
  } command_e;

  // Upper half of the status word for an unknown opcode
  localparam logic [15:0] STATUS_UNKNOWN_MARK = 16'hBAD0;

  // One upstream single-dword memory write
  typedef struct packed {
    logic [pcie_tlp_pkg::DW_WIDTH-1:0] addr;
    logic [pcie_tlp_pkg::DW_WIDTH-1:0] payload;
  } egress_req_t;

endpackage

// File: source/pcie_tlp_pkg.sv
// TLP types for a one-dword AXI-stream path; only 3-dword headers with 32-bit addresses are described
package pcie_tlp_pkg;

  localparam int DW_WIDTH     = 32;
  localparam int KEEP_WIDTH   = 4;
  localparam int BAR_COUNT    = 7;
  localparam int LENGTH_WIDTH = 10;
  localparam int BE_WIDTH     = 4;
  // TC, TD, EP and attribute bits of header dword 0
  localparam int FLAGS_WIDTH  = DW_WIDTH - 8 - LENGTH_WIDTH;

  // One beat of the receive or transmit stream
  typedef struct packed {
    logic [DW_WIDTH-1:0]   data;
    logic [KEEP_WIDTH-1:0] keep;
    logic                  last;
  } axis_beat_t;

  // Fmt in bits 7:5, type in bits 4:0
  typedef enum logic [7:0] {
    MEM_READ32  = 8'h00,
    MEM_WRITE32 = 8'h40
  } tlp_fmt_type_e;

  typedef logic [15:0] requester_id_t;
  typedef logic [7:0]  tlp_tag_t;

  typedef struct packed {
    tlp_fmt_type_e           fmt_type;
    logic [FLAGS_WIDTH-1:0]  flags;
    logic [LENGTH_WIDTH-1:0] length;
  } tlp_dw0_t;

  // Request header dword 1
  typedef struct packed {
    requester_id_t       requester_id;
    tlp_tag_t            tag;
    logic [BE_WIDTH-1:0] last_be;
    logic [BE_WIDTH-1:0] first_be;
  } tlp_dw1_t;

endpackage
